// File: files.f
src/game_pkg.sv
src/vga_if.sv
src/vga_timing.sv
src/button_decode.sv
src/game_update.sv
src/frame_draw.sv
src/game_top.sv
tests/clk_gen.sv
tests/game_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module game_tb \
    -Mdir obj_dir -o game_sim || exit 1
./obj_dir/game_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: tests/game_tb.sv
/* testbench for the paddle game: sync tracking, reference model,
   checking assertions and the test sequence */
`timescale 1ns/1ps
`default_nettype none

module game_tb;
    import game_pkg::*;

    localparam int H_ACTIVE  = 32;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 4;
    localparam int H_BACK    = 2;
    localparam int V_ACTIVE  = 24;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int PAD_W     = 8;
    localparam int PAD_H     = 2;
    localparam int PAD_STEP  = 4;
    localparam int BALL_SIZE = 2;
    localparam int BALL_STEP = 1;

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int PAD_MAX  = H_ACTIVE - PAD_W;
    localparam int BX_MAX   = H_ACTIVE - BALL_SIZE;
    localparam int BY_MAX   = V_ACTIVE - BALL_SIZE;
    localparam int LIMIT    = 40 * H_TOTAL * V_TOTAL + 20 * H_TOTAL;    // 40 frames + margin

    logic             clk_40;
    logic             reset;
    logic [4:0]       btn;    // indexed by command code
    logic             hsync;
    logic             vsync;
    logic [RGB_W-1:0] rgb;
    logic [15:0]      lfsr;
    logic             locked;
    logic             vs_prev;
    int               hc_t;    // coordinate of the pixel now at the outputs
    int               vc_t;
    game_state_t      m_state;
    int               m_p1;
    int               m_p2;
    int               mx;
    int               my;
    int               mdx;
    int               mdy;
    logic             in_blank;
    logic             exp_hsync;
    logic             exp_vsync;
    logic [RGB_W-1:0] exp_rgb;
    int               errors;
    int               err_mark;
    int               test_no;
    int               passed;
    int               failed;
    int               cycles;

    clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) clk_gen_i (.clk_40(clk_40), .reset(reset));

    game_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .PAD_W(PAD_W), .PAD_H(PAD_H), .PAD_STEP(PAD_STEP),
        .BALL_SIZE(BALL_SIZE), .BALL_STEP(BALL_STEP)
    ) dut_i (
        .clk_40(clk_40),
        .reset(reset),
        .btn_left1(btn[0]),
        .btn_right1(btn[1]),
        .btn_left2(btn[2]),
        .btn_right2(btn[3]),
        .btn_start(btn[4]),
        .hsync(hsync),
        .vsync(vsync),
        .rgb(rgb)
    );

    // 16 bit Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int pad_move(input int pos, input int delta);
        int n;
        n = pos + delta;
        if (n < 0)
            return 0;
        return (n > PAD_MAX) ? PAD_MAX : n;
    endfunction

    // one ball axis: a step past the limit parks the ball there and turns it
    task automatic ball_axis(input int pos, input int dir, input int lim,
                             output int npos, output int ndir);
        npos = pos + dir * BALL_STEP;
        ndir = dir;
        if (npos > lim) begin
            npos = lim;
            ndir = -1;
        end else if (npos < 0) begin
            npos = 0;
            ndir = 1;
        end
    endtask

    // ******************************************************************
    // sync tracking and ball model
    // ******************************************************************
    always @(posedge clk_40) begin : track
        int nx;
        int ndx;
        int ny;
        int ndy;
        if (reset) begin
            locked  <= 1'b0;
            vs_prev <= 1'b0;
            hc_t    <= 0;
            vc_t    <= 0;
            mx      <= BX_MAX / 2;    // centred
            my      <= BY_MAX / 2;
            mdx     <= 1;
            mdy     <= 1;
        end else begin
            vs_prev <= vsync;
            if (!locked) begin
                if (vsync && !vs_prev) begin    // first pixel of the first vsync line
                    locked <= 1'b1;
                    hc_t   <= 1;
                    vc_t   <= VS_START;
                end
            end else begin
                hc_t <= (hc_t == H_TOTAL - 1) ? 0 : hc_t + 1;
                if (hc_t == H_TOTAL - 1)
                    vc_t <= (vc_t == V_TOTAL - 1) ? 0 : vc_t + 1;
                // ball moves at frame start, pixel 0,0 still shows the old spot
                if (hc_t == 0 && vc_t == 0 && m_state == ST_PLAY) begin
                    ball_axis(mx, mdx, BX_MAX, nx, ndx);
                    ball_axis(my, mdy, BY_MAX, ny, ndy);
                    mx  <= nx;
                    mdx <= ndx;
                    my  <= ny;
                    mdy <= ndy;
                end
            end
        end
    end

    always_comb begin
        in_blank  = (hc_t >= H_ACTIVE) || (vc_t >= V_ACTIVE);
        exp_hsync = (hc_t >= HS_START) && (hc_t < HS_START + H_SYNC);
        exp_vsync = (vc_t >= VS_START) && (vc_t < VS_START + V_SYNC);
        if (in_blank)
            exp_rgb = '0;
        else if (m_state == ST_PLAY && hc_t >= mx && hc_t < mx + BALL_SIZE &&
                 vc_t >= my && vc_t < my + BALL_SIZE)
            exp_rgb = COL_BALL;
        else if (vc_t >= V_ACTIVE - PAD_H && hc_t >= m_p1 && hc_t < m_p1 + PAD_W)
            exp_rgb = COL_P1;
        else if (vc_t < PAD_H && hc_t >= m_p2 && hc_t < m_p2 + PAD_W)
            exp_rgb = COL_P2;
        else
            exp_rgb = COL_BG;
    end

    task automatic report_mismatch(input string what, input int got, input int want);
        errors++;
        $display("FAIL %0t: %s was %h, expected %h at pixel (%0d,%0d)",
                 $time, what, got, want, hc_t, vc_t);
    endtask

    // outputs change on the rising edge, checked on the falling one
    assert property (@(negedge clk_40) disable iff (reset) locked |-> hsync == exp_hsync)
        else report_mismatch("hsync", int'(hsync), int'(exp_hsync));
    assert property (@(negedge clk_40) disable iff (reset) locked |-> vsync == exp_vsync)
        else report_mismatch("vsync", int'(vsync), int'(exp_vsync));
    assert property (@(negedge clk_40) disable iff (reset) locked && in_blank |-> rgb == '0)
        else report_mismatch("blanking rgb", int'(rgb), 0);
    assert property (@(negedge clk_40) disable iff (reset)
        locked && !in_blank |-> rgb == exp_rgb)
        else report_mismatch("rgb", int'(rgb), int'(exp_rgb));

    // ******************************************************************
    // stimulus
    // ******************************************************************
    task automatic model_cmd(input int c);
        if (c == int'(CMD_START))
            m_state = (m_state == ST_IDLE) ? ST_PLAY : ST_IDLE;
        else if (m_state == ST_PLAY) begin    // paddles frozen in idle
            case (c)
                int'(CMD_P1_LEFT):  m_p1 = pad_move(m_p1, -PAD_STEP);
                int'(CMD_P1_RIGHT): m_p1 = pad_move(m_p1, PAD_STEP);
                int'(CMD_P2_LEFT):  m_p2 = pad_move(m_p2, -PAD_STEP);
                default:            m_p2 = pad_move(m_p2, PAD_STEP);
            endcase
        end
    endtask

    task automatic press_button(input int idx);
        btn[idx] = 1'b1;
        repeat (3) @(negedge clk_40);
        btn[idx] = 1'b0;
        repeat (3) @(negedge clk_40);
        model_cmd(idx);
    endtask

    task automatic press_all_dirs();
        btn[3:0] = 4'hf;
        repeat (3) @(negedge clk_40);
        btn[3:0] = 4'h0;
        repeat (8) @(negedge clk_40);    // queue drains one per cycle
        for (int i = 0; i < 4; i++)
            model_cmd(i);    // fixed priority, p1 left first
    endtask

    // returns at the first pixel of vertical blanking
    task automatic wait_blank();
        do
            @(negedge clk_40);
        while (!(locked && hc_t == 0 && vc_t == V_ACTIVE));
    endtask

    // returns on the falling edge where the outputs show pixel (h,v)
    task automatic wait_pixel(input int h, input int v);
        do
            @(negedge clk_40);
        while (!(locked && hc_t == h && vc_t == v));
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (errors == err_mark) begin
            passed++;
            $display("test %0d, %s: ok", test_no, name);
        end else begin
            failed++;
            $display("test %0d, %s: %0d mismatches", test_no, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(posedge clk_40) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        btn      = '0;
        lfsr     = 16'd29295;
        m_state  = ST_IDLE;
        m_p1     = PAD_MAX / 2;
        m_p2     = PAD_MAX / 2;
        errors   = 0;
        err_mark = 0;
        test_no  = 0;
        passed   = 0;
        failed   = 0;
        cycles   = 0;

        wait_blank();    // raster locked
        wait_blank();
        finish_test("idle frame after reset");

        repeat (2) begin
            repeat (4) press_button(rand_bits(2));
            wait_blank();
        end
        finish_test("presses in idle");

        press_button(int'(CMD_START));
        repeat (5) wait_blank();
        finish_test("start and ball motion");

        repeat (12) begin
            repeat (5) press_button(rand_bits(2));
            wait_blank();
        end
        finish_test("random paddle presses");

        repeat (7) press_button(int'(CMD_P1_RIGHT));
        repeat (7) press_button(int'(CMD_P2_LEFT));
        wait_blank();
        repeat (7) press_button(int'(CMD_P1_LEFT));
        repeat (7) press_button(int'(CMD_P2_RIGHT));
        wait_blank();
        finish_test("paddles clamped at both edges");

        // off the edges first, so a lost press shows
        press_button(int'(CMD_P1_RIGHT));
        press_button(int'(CMD_P2_LEFT));
        wait_blank();
        repeat (2) begin
            press_all_dirs();
            wait_blank();
        end
        finish_test("burst on all direction buttons");

        // queue still holds commands when the frame start stalls it
        wait_pixel(H_TOTAL - 5, V_TOTAL - 1);
        press_all_dirs();
        wait_blank();
        finish_test("commands held over frame start");

        press_button(int'(CMD_START));
        repeat (2) wait_blank();
        finish_test("second start freezes and hides ball");

        $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
                 test_no, passed, failed, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/clk_gen.sv
/* testbench clock and reset source */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_40,
    output logic reset
);

    initial begin
        clk_40 = 1'b0;
        forever #(PERIOD_NS / 2) clk_40 = ~clk_40;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_40);
        @(negedge clk_40);    // released on a falling edge
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: src/game_top.sv
/* top level of the paddle game: timing, button decode, game update
   and frame drawing */
`timescale 1ns/1ps
`default_nettype none

module game_top #(
    parameter int H_ACTIVE  = 800,
    parameter int H_FRONT   = 40,
    parameter int H_SYNC    = 128,
    parameter int H_BACK    = 88,
    parameter int V_ACTIVE  = 600,
    parameter int V_FRONT   = 1,
    parameter int V_SYNC    = 4,
    parameter int V_BACK    = 23,
    parameter int PAD_W     = 64,
    parameter int PAD_H     = 8,
    parameter int PAD_STEP  = 8,
    parameter int BALL_SIZE = 8,
    parameter int BALL_STEP = 2
) (
    input  logic                       clk_40,
    input  logic                       reset,
    input  logic                       btn_left1,
    input  logic                       btn_right1,
    input  logic                       btn_left2,
    input  logic                       btn_right2,
    input  logic                       btn_start,
    output logic                       hsync,
    output logic                       vsync,
    output logic [game_pkg::RGB_W-1:0] rgb
);
    import game_pkg::*;

    vga_if vga_tim();
    vga_if vga_out();

    logic               cmd_valid;
    logic               cmd_ready;
    cmd_t               cmd;
    logic [COORD_W-1:0] p1_x;
    logic [COORD_W-1:0] p2_x;
    logic [COORD_W-1:0] ball_x;
    logic [COORD_W-1:0] ball_y;
    game_state_t        state;

    assign hsync = vga_out.hsync;
    assign vsync = vga_out.vsync;
    assign rgb   = vga_out.rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (
        .clk_40(clk_40),
        .reset(reset),
        .vga_out(vga_tim)
    );

    button_decode u_button_decode (
        .clk_40(clk_40),
        .reset(reset),
        .btn_left1(btn_left1),
        .btn_right1(btn_right1),
        .btn_left2(btn_left2),
        .btn_right2(btn_right2),
        .btn_start(btn_start),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd)
    );

    game_update #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .PAD_W(PAD_W), .PAD_STEP(PAD_STEP),
        .BALL_SIZE(BALL_SIZE), .BALL_STEP(BALL_STEP)
    ) u_game_update (
        .clk_40(clk_40),
        .reset(reset),
        .vga_in(vga_tim),    // frame start only
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd(cmd),
        .p1_x(p1_x),
        .p2_x(p2_x),
        .ball_x(ball_x),
        .ball_y(ball_y),
        .state(state)
    );

    frame_draw #(
        .V_ACTIVE(V_ACTIVE), .PAD_W(PAD_W), .PAD_H(PAD_H), .BALL_SIZE(BALL_SIZE)
    ) u_frame_draw (
        .clk_40(clk_40),
        .reset(reset),
        .vga_in(vga_tim),
        .vga_out(vga_out),
        .p1_x(p1_x),
        .p2_x(p2_x),
        .ball_x(ball_x),
        .ball_y(ball_y),
        .state(state)
    );

endmodule

`default_nettype wire

// File: src/frame_draw.sv
/* frame renderer: background, both paddles and the ball,
   one register stage on the raster */
`timescale 1ns/1ps
`default_nettype none

module frame_draw #(
    parameter int V_ACTIVE  = 600,
    parameter int PAD_W     = 64,
    parameter int PAD_H     = 8,
    parameter int BALL_SIZE = 8
) (
    input  logic                          clk_40,
    input  logic                          reset,
    vga_if.sink                           vga_in,
    vga_if.source                         vga_out,
    input  logic [game_pkg::COORD_W-1:0]  p1_x,
    input  logic [game_pkg::COORD_W-1:0]  p2_x,
    input  logic [game_pkg::COORD_W-1:0]  ball_x,
    input  logic [game_pkg::COORD_W-1:0]  ball_y,
    input  game_pkg::game_state_t         state
);
    import game_pkg::*;

    logic [COORD_W-1:0] hc;
    logic [COORD_W-1:0] vc;
    logic               in_ball;
    logic               in_p1;
    logic               in_p2;
    logic [RGB_W-1:0]   rgb_nxt;

    assign hc = vga_in.hcount;
    assign vc = vga_in.vcount;

    assign in_ball = (state == ST_PLAY) &&    // hidden in idle
                     (hc >= ball_x) && (hc < ball_x + COORD_W'(BALL_SIZE)) &&
                     (vc >= ball_y) && (vc < ball_y + COORD_W'(BALL_SIZE));
    assign in_p1   = (vc >= COORD_W'(V_ACTIVE - PAD_H)) &&
                     (hc >= p1_x) && (hc < p1_x + COORD_W'(PAD_W));
    assign in_p2   = (vc < COORD_W'(PAD_H)) &&
                     (hc >= p2_x) && (hc < p2_x + COORD_W'(PAD_W));

    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk)
            rgb_nxt = '0;
        else if (in_ball)
            rgb_nxt = COL_BALL;
        else if (in_p1)
            rgb_nxt = COL_P1;
        else if (in_p2)
            rgb_nxt = COL_P2;
        else
            rgb_nxt = COL_BG;
    end

    // whole raster moves one cycle together
    always_ff @(posedge clk_40) begin
        if (reset) begin
            vga_out.hcount <= '0;
            vga_out.vcount <= '0;
            vga_out.hsync  <= 1'b0;
            vga_out.vsync  <= 1'b0;
            vga_out.hblnk  <= 1'b0;
            vga_out.vblnk  <= 1'b0;
            vga_out.rgb    <= '0;
        end else begin
            vga_out.hcount <= vga_in.hcount;
            vga_out.vcount <= vga_in.vcount;
            vga_out.hsync  <= vga_in.hsync;
            vga_out.vsync  <= vga_in.vsync;
            vga_out.hblnk  <= vga_in.hblnk;
            vga_out.vblnk  <= vga_in.vblnk;
            vga_out.rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/game_update.sv
/* game state FSM, paddle positions and per-frame ball motion */
`timescale 1ns/1ps
`default_nettype none

module game_update #(
    parameter int H_ACTIVE  = 800,
    parameter int V_ACTIVE  = 600,
    parameter int PAD_W     = 64,
    parameter int PAD_STEP  = 8,
    parameter int BALL_SIZE = 8,
    parameter int BALL_STEP = 2
) (
    input  logic                          clk_40,
    input  logic                          reset,
    vga_if.sink                           vga_in,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  game_pkg::cmd_t                cmd,
    output logic [game_pkg::COORD_W-1:0]  p1_x,
    output logic [game_pkg::COORD_W-1:0]  p2_x,
    output logic [game_pkg::COORD_W-1:0]  ball_x,
    output logic [game_pkg::COORD_W-1:0]  ball_y,
    output game_pkg::game_state_t         state
);
    import game_pkg::*;

    localparam logic [COORD_W-1:0] PAD_MAX    = COORD_W'(H_ACTIVE - PAD_W);
    localparam logic [COORD_W-1:0] BALL_X_MAX = COORD_W'(H_ACTIVE - BALL_SIZE);
    localparam logic [COORD_W-1:0] BALL_Y_MAX = COORD_W'(V_ACTIVE - BALL_SIZE);

    logic               frame_start;
    logic               take;
    logic               dir_x;     // 1 moves right
    logic               dir_y;     // 1 moves down
    logic [COORD_W:0]   next_x;    // {dir, position}
    logic [COORD_W:0]   next_y;

    // paddle step, clamped to the screen
    function automatic logic [COORD_W-1:0] pad_move(
        input logic [COORD_W-1:0] pos,
        input logic               right
    );
        if (right)
            return (pos + COORD_W'(PAD_STEP) > PAD_MAX) ? PAD_MAX : pos + COORD_W'(PAD_STEP);
        return (pos < COORD_W'(PAD_STEP)) ? '0 : pos - COORD_W'(PAD_STEP);
    endfunction

    // one axis of the ball, bounce by parking at the limit
    function automatic logic [COORD_W:0] ball_step(
        input logic [COORD_W-1:0] pos,
        input logic               dir,
        input logic [COORD_W-1:0] lim
    );
        if (dir) begin
            if (pos + COORD_W'(BALL_STEP) > lim)
                return {1'b0, lim};
            return {1'b1, pos + COORD_W'(BALL_STEP)};
        end
        if (pos < COORD_W'(BALL_STEP))
            return {1'b1, {COORD_W{1'b0}}};
        return {1'b0, pos - COORD_W'(BALL_STEP)};
    endfunction

    assign frame_start = (vga_in.hcount == '0) && (vga_in.vcount == '0);
    assign cmd_ready   = !frame_start;    // frame start belongs to the ball
    assign take        = cmd_valid && cmd_ready;
    assign next_x      = ball_step(ball_x, dir_x, BALL_X_MAX);
    assign next_y      = ball_step(ball_y, dir_y, BALL_Y_MAX);

    always_ff @(posedge clk_40) begin
        if (reset) begin
            state  <= ST_IDLE;
            p1_x   <= COORD_W'((H_ACTIVE - PAD_W) / 2);
            p2_x   <= COORD_W'((H_ACTIVE - PAD_W) / 2);
            ball_x <= COORD_W'((H_ACTIVE - BALL_SIZE) / 2);
            ball_y <= COORD_W'((V_ACTIVE - BALL_SIZE) / 2);
            dir_x  <= 1'b1;
            dir_y  <= 1'b1;
        end else begin
            if (take && cmd == CMD_START)
                state <= (state == ST_IDLE) ? ST_PLAY : ST_IDLE;
            if (take && state == ST_PLAY) begin
                case (cmd)
                    CMD_P1_LEFT:  p1_x <= pad_move(p1_x, 1'b0);
                    CMD_P1_RIGHT: p1_x <= pad_move(p1_x, 1'b1);
                    CMD_P2_LEFT:  p2_x <= pad_move(p2_x, 1'b0);
                    CMD_P2_RIGHT: p2_x <= pad_move(p2_x, 1'b1);
                    default: ;
                endcase
            end
            if (frame_start && state == ST_PLAY) begin
                {dir_x, ball_x} <= next_x;
                {dir_y, ball_y} <= next_y;
            end
        end
    end

    assert property (@(posedge clk_40) disable iff (reset)
        ball_x <= BALL_X_MAX && ball_y <= BALL_Y_MAX)
        else $error("ball outside the active area");

endmodule

`default_nettype wire

// File: src/button_decode.sv
/* button synchronizers, press detection and a four-entry command queue
   with valid/ready output */
`timescale 1ns/1ps
`default_nettype none

module button_decode (
    input  logic           clk_40,
    input  logic           reset,
    input  logic           btn_left1,
    input  logic           btn_right1,
    input  logic           btn_left2,
    input  logic           btn_right2,
    input  logic           btn_start,
    output logic           cmd_valid,
    input  logic           cmd_ready,
    output game_pkg::cmd_t cmd
);
    import game_pkg::*;

    localparam int N_BTN = 5;
    localparam int DEPTH = 4;

    logic [N_BTN-1:0] sync_q1;
    logic [N_BTN-1:0] sync_q2;
    logic [N_BTN-1:0] btn_prev;
    logic [N_BTN-1:0] pending;    // presses still waiting for the queue
    logic [N_BTN-1:0] req;
    logic [N_BTN-1:0] pick;
    cmd_t             pick_cmd;
    cmd_t             fifo_mem [DEPTH];
    logic [1:0]       wr_ptr;
    logic [1:0]       rd_ptr;
    logic [2:0]       count;
    logic             push;
    logic             pop;

    // ******************************************************************
    // synchronizer and edge detect
    // ******************************************************************
    always_ff @(posedge clk_40) begin
        if (reset) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            btn_prev <= '0;
            pending  <= '0;
        end else begin
            sync_q1  <= {btn_start, btn_right2, btn_left2, btn_right1, btn_left1};
            sync_q2  <= sync_q1;
            btn_prev <= sync_q2;
            pending  <= req & ~pick;    // picked one leaves, even if dropped
        end
    end

    assign req = pending | (sync_q2 & ~btn_prev);

    // lowest bit wins, the rest wait a cycle
    always_comb begin
        pick     = '0;
        pick_cmd = CMD_P1_LEFT;
        for (int i = N_BTN - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick     = N_BTN'(1) << i;
                pick_cmd = cmd_t'(3'(i));
            end
        end
    end

    // ******************************************************************
    // command queue
    // ******************************************************************
    assign push      = (|req) && (count != 3'(DEPTH));    // full queue drops it
    assign pop       = cmd_valid && cmd_ready;
    assign cmd_valid = (count != '0);
    assign cmd       = fifo_mem[rd_ptr];

    always_ff @(posedge clk_40) begin
        if (push)
            fifo_mem[wr_ptr] <= pick_cmd;
    end

    always_ff @(posedge clk_40) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + 3'(push) - 3'(pop);
        end
    end

    assert property (@(posedge clk_40) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
        else $error("command changed while stalled");

endmodule

`default_nettype wire

// File: src/vga_timing.sv
/* raster timing generator: line and frame counters with sync
   and blanking windows */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 800,
    parameter int H_FRONT  = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BACK   = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BACK   = 23
) (
    input  logic  clk_40,
    input  logic  reset,
    vga_if.source vga_out
);
    import game_pkg::*;

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;

    logic [COORD_W-1:0] hcount;
    logic [COORD_W-1:0] vcount;

    always_ff @(posedge clk_40) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (hcount == COORD_W'(H_TOTAL - 1)) begin
            hcount <= '0;    // end of line
            vcount <= (vcount == COORD_W'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    assign vga_out.hcount = hcount;
    assign vga_out.vcount = vcount;
    assign vga_out.hblnk  = (hcount >= COORD_W'(H_ACTIVE));
    assign vga_out.vblnk  = (vcount >= COORD_W'(V_ACTIVE));
    assign vga_out.hsync  = (hcount >= COORD_W'(HS_START)) &&
                            (hcount < COORD_W'(HS_START + H_SYNC));
    assign vga_out.vsync  = (vcount >= COORD_W'(VS_START)) &&
                            (vcount < COORD_W'(VS_START + V_SYNC));
    assign vga_out.rgb    = '0;    // black, painted over by frame_draw

    assert property (@(posedge clk_40) disable iff (reset)
        hcount < COORD_W'(H_TOTAL))
        else $error("hcount beyond line length");

endmodule

`default_nettype wire

// File: src/vga_if.sv
/* raster timing and pixel bundle with source and sink modports */
`timescale 1ns/1ps
`default_nettype none

interface vga_if;
    import game_pkg::*;

    logic [COORD_W-1:0] hcount;
    logic [COORD_W-1:0] vcount;
    logic               hsync;
    logic               vsync;
    logic               hblnk;
    logic               vblnk;
    logic [RGB_W-1:0]   rgb;

    modport source (output hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);
    modport sink (input hcount, vcount, hsync, vsync, hblnk, vblnk, rgb);

endinterface

`default_nettype wire

// File: src/game_pkg.sv
/* shared definitions for the paddle game: coordinate and colour widths,
   decoded commands, game states and the palette */
`default_nettype none

package game_pkg;

    localparam int COORD_W = 12;
    localparam int RGB_W = 12;    // 4 bits per channel

    // bit order of the button vector in button_decode follows this encoding
    typedef enum logic [2:0] {
        CMD_P1_LEFT  = 3'd0,
        CMD_P1_RIGHT = 3'd1,
        CMD_P2_LEFT  = 3'd2,
        CMD_P2_RIGHT = 3'd3,
        CMD_START    = 3'd4
    } cmd_t;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_PLAY = 1'b1
    } game_state_t;

    // ******************************************************************
    // palette, none of these is black
    // ******************************************************************
    localparam logic [RGB_W-1:0] COL_BG   = 12'h125;  // dark blue field
    localparam logic [RGB_W-1:0] COL_P1   = 12'hf40;
    localparam logic [RGB_W-1:0] COL_P2   = 12'h0c4;
    localparam logic [RGB_W-1:0] COL_BALL = 12'hfff;

endpackage

`default_nettype wire
